/* list.f */
source/fetch_pkg.sv
source/fetch_window_if.sv
source/pc_gen.sv
source/branch_predictor.sv
source/fetch_align.sv
source/fetch_queue.sv
source/frontend.sv
sim/frontend_assert.sv
sim/frontend_checker.sv
sim/tb_frontend.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch frontend simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_frontend -f list.f

out="$(./obj_dir/Vtb_frontend)"
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
   exit 0
fi
exit 1

/* sim/tb_frontend.sv */
//##########################################################################
// Fetch frontend testbench
// Clock, reset, instruction memory, stimulus table and watchdog
//##########################################################################
`timescale 1ns/100ps

module tb_frontend;
   import fetch_pkg::*;

   localparam int NROWS = 10;
   localparam int RST_CYCLES = 16;

   // Pop mode 0 pops all valid, 1 holds for hold cycles, 2 pops at random
   typedef struct packed
   {
      logic       flush;
      pc_t        tgt;
      logic       wb;
      logic       taken;
      pc_t        wb_pc;
      pc_t        wb_tgt;
      bpu_upd_t   wb_upd;
      logic [1:0] mode;
      logic [15:0] hold;
      logic [15:0] cycles;
   } row_t;

   row_t rows [NROWS] = '{
      '{1'b0, 30'h000, 1'b0, 1'b0, 30'h000, 30'h000, 3'b000, 2'd0, 16'd0,  16'd40},
      '{1'b1, 30'h201, 1'b0, 1'b0, 30'h000, 30'h000, 3'b000, 2'd0, 16'd0,  16'd30},
      '{1'b1, 30'h080, 1'b1, 1'b1, 30'h090, 30'h0A3, 3'b001, 2'd0, 16'd0,  16'd30},
      '{1'b1, 30'h080, 1'b1, 1'b1, 30'h090, 30'h0A3, 3'b010, 2'd0, 16'd0,  16'd30},
      '{1'b1, 30'h085, 1'b0, 1'b0, 30'h000, 30'h000, 3'b000, 2'd1, 16'd20, 16'd50},
      '{1'b1, 30'h080, 1'b1, 1'b0, 30'h090, 30'h0A3, 3'b111, 2'd0, 16'd0,  16'd30},
      '{1'b1, 30'h080, 1'b1, 1'b0, 30'h090, 30'h0A3, 3'b110, 2'd0, 16'd0,  16'd30},
      '{1'b1, 30'h300, 1'b0, 1'b0, 30'h000, 30'h000, 3'b000, 2'd2, 16'd0,  16'd60},
      '{1'b0, 30'h000, 1'b0, 1'b0, 30'h000, 30'h000, 3'b000, 2'd1, 16'd10, 16'd10},
      '{1'b1, 30'h400, 1'b0, 1'b0, 30'h000, 30'h000, 3'b000, 2'd0, 16'd0,  16'd30}
   };

   logic clk;
   logic rst_n;
   logic flush;
   pc_t flush_tgt;
   logic imem_en;
   logic [ADDR_W-1:0] imem_addr;
   window_t imem_rdata;
   logic [FW-1:0] id_valid;
   cnt_t id_pop_cnt;
   insn_t id_ins0;
   insn_t id_ins1;
   pc_t id_pc0;
   pc_t id_pc1;
   bpu_upd_t id_bpu_upd0;
   bpu_upd_t id_bpu_upd1;
   logic bpu_wb;
   logic bpu_wb_taken;
   pc_t bpu_wb_pc;
   pc_t bpu_wb_npc_act;
   bpu_upd_t bpu_wb_upd;
   int err_cnt;
   int lane_cnt;
   logic mem_en;
   logic [ADDR_W-1:0] mem_addr;

   frontend u_dut (.*);

   frontend_checker u_checker (.*);

   function automatic insn_t mem_word(logic [ADDR_W-1:0] w);
      return w ^ 32'hA5A5_0000;
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Synchronous instruction memory with one cycle of latency
   always
   begin
      @(negedge clk);
      mem_en = imem_en;
      mem_addr = imem_addr;
      @(posedge clk);
      #2;
      if (mem_en)
         imem_rdata = {mem_word((mem_addr >> 2) + 1), mem_word(mem_addr >> 2)};
   end

   initial
   begin
      int total;
      total = RST_CYCLES;
      for (int r = 0; r < NROWS; r++)
         total += int'(rows[r].cycles);
      #((total + 200) * 20);
      $display("Watchdog expired before the stimulus table finished");
      $display("Test failed");
      $finish;
   end

   initial
   begin
      cnt_t avail;
      void'($urandom(32'h0339_3751));
      rst_n = 1'b0;
      flush = 1'b0;
      flush_tgt = '0;
      imem_rdata = '0;
      id_pop_cnt = '0;
      bpu_wb = 1'b0;
      bpu_wb_taken = 1'b0;
      bpu_wb_pc = '0;
      bpu_wb_npc_act = '0;
      bpu_wb_upd = '0;
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int r = 0; r < NROWS; r++)
      begin
         for (int c = 0; c < int'(rows[r].cycles); c++)
         begin
            @(posedge clk);
            #2;
            flush = (c == 0) && rows[r].flush;
            flush_tgt = rows[r].tgt;
            bpu_wb = (c == 0) && rows[r].wb;
            bpu_wb_taken = rows[r].taken;
            bpu_wb_pc = rows[r].wb_pc;
            bpu_wb_npc_act = rows[r].wb_tgt;
            bpu_wb_upd = rows[r].wb_upd;
            avail = cnt_t'(id_valid[0]) + cnt_t'(id_valid[1]);
            if (flush)
               id_pop_cnt = '0;
            else if (rows[r].mode == 2'd1 && c < int'(rows[r].hold))
               id_pop_cnt = '0;
            else if (rows[r].mode == 2'd2)
               id_pop_cnt = cnt_t'($urandom_range(0, int'(avail)));
            else
               id_pop_cnt = avail;
         end
      end
      @(posedge clk);
      #2;
      flush = 1'b0;
      bpu_wb = 1'b0;
      id_pop_cnt = '0;
      @(posedge clk);
      if (lane_cnt == 0)
         $display("No instruction was ever popped from the frontend");
      $display("Lanes checked %0d, errors %0d", lane_cnt, err_cnt);
      if (err_cnt == 0 && lane_cnt != 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* sim/frontend_checker.sv */
//##########################################################################
// Fetch stream checker
// Models the expected PC stream and compares every popped decode lane
//##########################################################################
`timescale 1ns/100ps

module frontend_checker
(
   input                                  clk,
   input                                  rst_n,
   input                                  flush,
   input  fetch_pkg::pc_t                 flush_tgt,
   input                                  bpu_wb,
   input                                  bpu_wb_taken,
   input  fetch_pkg::pc_t                 bpu_wb_pc,
   input  fetch_pkg::pc_t                 bpu_wb_npc_act,
   input  fetch_pkg::bpu_upd_t            bpu_wb_upd,
   input  [fetch_pkg::FW-1:0]             id_valid,
   input  fetch_pkg::cnt_t                id_pop_cnt,
   input  fetch_pkg::insn_t               id_ins0,
   input  fetch_pkg::insn_t               id_ins1,
   input  fetch_pkg::pc_t                 id_pc0,
   input  fetch_pkg::pc_t                 id_pc1,
   input  fetch_pkg::bpu_upd_t            id_bpu_upd0,
   input  fetch_pkg::bpu_upd_t            id_bpu_upd1,
   output int                             err_cnt,
   output int                             lane_cnt
);
   import fetch_pkg::*;

   localparam logic [31:0] INS_KEY = 32'hA5A5_0000;
   // Cycles without a pop after which both lanes must be filled
   localparam int FILL_CYCLES = 8;

   // Direct-mapped model of the target buffer
   logic m_vld [16];
   pc_t m_pc [16];
   pc_t m_tgt [16];
   logic [1:0] m_cnt [16];
   pc_t exp_pc;
   int idle_cyc;

   function automatic logic predicts(pc_t pc);
      logic [3:0] idx;
      idx = pc[3:0];
      return m_vld[idx] && (m_pc[idx] == pc) && (m_cnt[idx] >= 2'd2);
   endfunction

   task automatic train();
      logic [3:0] idx;
      logic [1:0] c;
      idx = bpu_wb_pc[3:0];
      c = bpu_wb_upd[1:0];
      if (bpu_wb_taken)
         c = (c == 2'd3) ? c : c + 2'd1;
      else
         c = (c == 2'd0) ? c : c - 2'd1;
      m_vld[idx] = 1'b1;
      m_pc[idx] = bpu_wb_pc;
      m_tgt[idx] = bpu_wb_npc_act;
      m_cnt[idx] = c;
   endtask

   task automatic check_lane(int lane, pc_t pc, insn_t ins, bpu_upd_t upd);
      insn_t exp_ins;
      logic exp_pred;
      exp_ins = {2'b00, exp_pc} ^ INS_KEY;
      exp_pred = predicts(exp_pc);
      lane_cnt++;
      if (pc !== exp_pc)
      begin
         err_cnt++;
         $display("[ERROR] %0t id_pc%0d got %h expected %h", $time, lane, pc, exp_pc);
      end
      if (ins !== exp_ins)
      begin
         err_cnt++;
         $display("[ERROR] %0t id_ins%0d got %h expected %h", $time, lane, ins, exp_ins);
      end
      if (upd[BPU_TAKEN] !== exp_pred)
      begin
         err_cnt++;
         $display("[ERROR] %0t id_bpu_upd%0d[2] got %b expected %b",
                  $time, lane, upd[BPU_TAKEN], exp_pred);
      end
      // Follow the trained target after a predicted branch
      exp_pc = exp_pred ? m_tgt[exp_pc[3:0]] : exp_pc + pc_t'(1);
   endtask

   // Sample mid-cycle and model the coming edge
   always @(negedge clk)
   begin
      if (!rst_n)
      begin
         err_cnt = 0;
         lane_cnt = 0;
         idle_cyc = 0;
         exp_pc = ERST_VECTOR[ADDR_W-1:P_INSN_LEN];
         for (int i = 0; i < 16; i++)
            m_vld[i] = 1'b0;
      end
      else if (flush)
      begin
         if (bpu_wb)
            train();
         exp_pc = flush_tgt;
         idle_cyc = 0;
      end
      else
      begin
         if (bpu_wb)
            train();
         // Stalled decode sees a queue holding at least two entries
         if (idle_cyc >= FILL_CYCLES && id_valid !== 2'b11)
         begin
            err_cnt++;
            $display("[ERROR] %0t id_valid got %b expected %b", $time, id_valid, 2'b11);
         end
         if (id_pop_cnt >= cnt_t'(1))
            check_lane(0, id_pc0, id_ins0, id_bpu_upd0);
         if (id_pop_cnt == cnt_t'(2))
            check_lane(1, id_pc1, id_ins1, id_bpu_upd1);
         idle_cyc = (id_pop_cnt == '0) ? idle_cyc + 1 : 0;
      end
   end

endmodule

/* sim/frontend_assert.sv */
//##########################################################################
// Fetch queue assertions
// Output lane pattern, occupancy bound and flush behavior of the queue
//##########################################################################
`timescale 1ns/100ps

module frontend_assert
(
   input                                  clk,
   input                                  rst_n,
   input                                  flush,
   input  fetch_pkg::cnt_t                push_cnt,
   input  [fetch_pkg::FW-1:0]             id_valid,
   input  fetch_pkg::pc_t                 id_pc0,
   input  fetch_pkg::pc_t                 id_pc1,
   input  fetch_pkg::bpu_upd_t            id_bpu_upd0,
   input  [fetch_pkg::IQ_P_DEPTH:0]       count
);
   import fetch_pkg::*;

   // Lane 1 needs lane 0 and follows it unless lane 0 jumps
   lane_order: assert property (@(posedge clk) disable iff (!rst_n)
                                (id_valid != 2'b10) &&
                                ((id_valid != 2'b11) || id_bpu_upd0[BPU_TAKEN] ||
                                 (id_pc1 == id_pc0 + pc_t'(1))))
      else $error("decode lanes are out of order");

   occupancy: assert property (@(posedge clk) disable iff (!rst_n)
                               int'(count) <= (1 << IQ_P_DEPTH))
      else $error("queue occupancy %0d exceeds the depth", count);

   // Stale stage-2 window must not land after a flush
   flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
                                 flush |=> (id_valid == '0) && (push_cnt == '0))
      else $error("queue shows or receives entries in the cycle after a flush");

endmodule

bind fetch_queue frontend_assert u_assert
(
   .clk          (clk),
   .rst_n        (rst_n),
   .flush        (flush),
   .push_cnt     (push_cnt),
   .id_valid     (id_valid),
   .id_pc0       (id_pc0),
   .id_pc1       (id_pc1),
   .id_bpu_upd0  (id_bpu_upd0),
   .count        (count)
);

/* source/frontend.sv */
//##########################################################################
// Fetch frontend top
// PC stage, predictor, align stage and queue between imem and decode
//##########################################################################
`timescale 1ns/100ps

module frontend
(
   input                                  clk,
   input                                  rst_n,
   input                                  flush,
   input  fetch_pkg::pc_t                 flush_tgt,
   output logic                           imem_en,
   output logic [fetch_pkg::ADDR_W-1:0]   imem_addr,
   input  fetch_pkg::window_t             imem_rdata,
   output logic [fetch_pkg::FW-1:0]       id_valid,
   input  fetch_pkg::cnt_t                id_pop_cnt,
   output fetch_pkg::insn_t               id_ins0,
   output fetch_pkg::insn_t               id_ins1,
   output fetch_pkg::pc_t                 id_pc0,
   output fetch_pkg::pc_t                 id_pc1,
   output fetch_pkg::bpu_upd_t            id_bpu_upd0,
   output fetch_pkg::bpu_upd_t            id_bpu_upd1,
   input                                  bpu_wb,
   input                                  bpu_wb_taken,
   input  fetch_pkg::pc_t                 bpu_wb_pc,
   input  fetch_pkg::pc_t                 bpu_wb_npc_act,
   input  fetch_pkg::bpu_upd_t            bpu_wb_upd
);
   import fetch_pkg::*;

   logic iq_ready;
   logic pred_taken;
   pc_t pred_tgt;
   pc_t lookup_pc0;
   pc_t lookup_pc1;
   bpu_upd_t upd0;
   bpu_upd_t upd1;
   cnt_t s1_push_cnt;
   cnt_t push_cnt;
   insn_t push_ins0;
   insn_t push_ins1;
   pc_t push_pc0;
   pc_t push_pc1;
   bpu_upd_t push_upd0;
   bpu_upd_t push_upd1;

   fetch_window_if u_win ();

   pc_gen u_pc_gen
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .flush            (flush),
      .flush_tgt        (flush_tgt),
      .iq_ready         (iq_ready),
      .pred_taken       (pred_taken),
      .pred_tgt         (pred_tgt),
      .push_cnt         (s1_push_cnt),
      .imem_en          (imem_en),
      .imem_addr        (imem_addr),
      .lookup_pc0       (lookup_pc0),
      .lookup_pc1       (lookup_pc1),
      .win              (u_win.src)
   );

   // Lookup advances with the pipe
   branch_predictor u_bpu
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .re               (iq_ready),
      .flush            (flush),
      .lookup_pc0       (lookup_pc0),
      .lookup_pc1       (lookup_pc1),
      .aligned_s1       (u_win.aligned),
      .pred_taken       (pred_taken),
      .pred_tgt         (pred_tgt),
      .upd0             (upd0),
      .upd1             (upd1),
      .bpu_wb           (bpu_wb),
      .bpu_wb_taken     (bpu_wb_taken),
      .bpu_wb_pc        (bpu_wb_pc),
      .bpu_wb_npc_act   (bpu_wb_npc_act),
      .bpu_wb_upd       (bpu_wb_upd)
   );

   fetch_align u_align
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .flush            (flush),
      .iq_ready         (iq_ready),
      .win              (u_win.dst),
      .upd0             (upd0),
      .upd1             (upd1),
      .imem_rdata       (imem_rdata),
      .s1_push_cnt      (s1_push_cnt),
      .push_cnt         (push_cnt),
      .push_ins0        (push_ins0),
      .push_ins1        (push_ins1),
      .push_pc0         (push_pc0),
      .push_pc1         (push_pc1),
      .push_upd0        (push_upd0),
      .push_upd1        (push_upd1)
   );

   fetch_queue u_iq
   (
      .clk              (clk),
      .rst_n            (rst_n),
      .flush            (flush),
      .push_cnt         (push_cnt),
      .push_ins0        (push_ins0),
      .push_ins1        (push_ins1),
      .push_pc0         (push_pc0),
      .push_pc1         (push_pc1),
      .push_upd0        (push_upd0),
      .push_upd1        (push_upd1),
      .id_pop_cnt       (id_pop_cnt),
      .iq_ready         (iq_ready),
      .id_valid         (id_valid),
      .id_ins0          (id_ins0),
      .id_ins1          (id_ins1),
      .id_pc0           (id_pc0),
      .id_pc1           (id_pc1),
      .id_bpu_upd0      (id_bpu_upd0),
      .id_bpu_upd1      (id_bpu_upd1)
   );

endmodule

/* source/fetch_queue.sv */
//##########################################################################
// Fetch queue
// Circular instruction buffer with two-wide push and two-wide pop
//##########################################################################
`timescale 1ns/100ps

module fetch_queue
(
   input                                  clk,
   input                                  rst_n,
   input                                  flush,
   input  fetch_pkg::cnt_t                push_cnt,
   input  fetch_pkg::insn_t               push_ins0,
   input  fetch_pkg::insn_t               push_ins1,
   input  fetch_pkg::pc_t                 push_pc0,
   input  fetch_pkg::pc_t                 push_pc1,
   input  fetch_pkg::bpu_upd_t            push_upd0,
   input  fetch_pkg::bpu_upd_t            push_upd1,
   input  fetch_pkg::cnt_t                id_pop_cnt,
   output logic                           iq_ready,
   output logic [fetch_pkg::FW-1:0]       id_valid,
   output fetch_pkg::insn_t               id_ins0,
   output fetch_pkg::insn_t               id_ins1,
   output fetch_pkg::pc_t                 id_pc0,
   output fetch_pkg::pc_t                 id_pc1,
   output fetch_pkg::bpu_upd_t            id_bpu_upd0,
   output fetch_pkg::bpu_upd_t            id_bpu_upd1
);
   import fetch_pkg::*;

   insn_t ins_mem [1<<IQ_P_DEPTH];
   pc_t pc_mem [1<<IQ_P_DEPTH];
   bpu_upd_t upd_mem [1<<IQ_P_DEPTH];

   logic [IQ_P_DEPTH-1:0] wptr;
   logic [IQ_P_DEPTH-1:0] wptr_1;
   logic [IQ_P_DEPTH-1:0] rptr;
   logic [IQ_P_DEPTH-1:0] rptr_1;
   logic [IQ_P_DEPTH:0] count;
   logic [IQ_P_DEPTH:0] count_nxt;

   assign wptr_1 = wptr + 1'b1;
   assign rptr_1 = rptr + 1'b1;
   assign count_nxt = count + {{(IQ_P_DEPTH-P_FW){1'b0}}, push_cnt}
                            - {{(IQ_P_DEPTH-P_FW){1'b0}}, id_pop_cnt};

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wptr <= '0;
         rptr <= '0;
         count <= '0;
         iq_ready <= 1'b0;
      end
      else if (flush)
      begin
         wptr <= '0;
         rptr <= '0;
         count <= '0;
         iq_ready <= 1'b1;
      end
      else
      begin
         wptr <= wptr + {{(IQ_P_DEPTH-P_FW-1){1'b0}}, push_cnt};
         rptr <= rptr + {{(IQ_P_DEPTH-P_FW-1){1'b0}}, id_pop_cnt};
         count <= count_nxt;
         // Room for two windows in flight plus the landing push
         iq_ready <= (int'(count_nxt) <= (1 << IQ_P_DEPTH) - IQ_READY_FREE);
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_cnt >= cnt_t'(1))
      begin
         ins_mem[wptr] <= push_ins0;
         pc_mem[wptr] <= push_pc0;
         upd_mem[wptr] <= push_upd0;
      end
      if (push_cnt == cnt_t'(FW))
      begin
         ins_mem[wptr_1] <= push_ins1;
         pc_mem[wptr_1] <= push_pc1;
         upd_mem[wptr_1] <= push_upd1;
      end
   end

   // Occupied lanes are contiguous from lane 0
   always_comb
   begin
      for (int i = 0; i < FW; i++)
         id_valid[i] = (int'(count) > i);
   end

   assign id_ins0 = ins_mem[rptr];
   assign id_ins1 = ins_mem[rptr_1];
   assign id_pc0 = pc_mem[rptr];
   assign id_pc1 = pc_mem[rptr_1];
   assign id_bpu_upd0 = upd_mem[rptr];
   assign id_bpu_upd1 = upd_mem[rptr_1];

endmodule

/* source/fetch_align.sv */
//##########################################################################
// Fetch align stage
// Taken mask, push count and the stage-2 register in front of the queue
//##########################################################################
`timescale 1ns/100ps

module fetch_align
(
   input                                  clk,
   input                                  rst_n,
   input                                  flush,
   input                                  iq_ready,
   fetch_window_if.dst                    win,
   input  fetch_pkg::bpu_upd_t            upd0,
   input  fetch_pkg::bpu_upd_t            upd1,
   input  fetch_pkg::window_t             imem_rdata,
   output fetch_pkg::cnt_t                s1_push_cnt,
   output fetch_pkg::cnt_t                push_cnt,
   output fetch_pkg::insn_t               push_ins0,
   output fetch_pkg::insn_t               push_ins1,
   output fetch_pkg::pc_t                 push_pc0,
   output fetch_pkg::pc_t                 push_pc1,
   output fetch_pkg::bpu_upd_t            push_upd0,
   output fetch_pkg::bpu_upd_t            push_upd1
);
   import fetch_pkg::*;

   logic [FW-1:0] valid_msk;
   logic [FW-1:0] push_msk;
   logic first_slot;
   cnt_t push_cnt_q;

   // Slot 1 is dropped behind a taken slot 0
   assign valid_msk = {~upd0[BPU_TAKEN], 1'b1};
   assign push_msk = win.aligned & valid_msk & {FW{win.valid}};
   assign s1_push_cnt = cnt_t'(push_msk[0]) + cnt_t'(push_msk[1]);

   // Odd entry word, so slot 1 goes to lane 0
   assign first_slot = ~win.aligned[0];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         push_cnt_q <= '0;
      else if (iq_ready | flush)
         push_cnt_q <= flush ? '0 : s1_push_cnt;
   end

   always_ff @(posedge clk)
   begin
      if (iq_ready)
      begin
         push_ins0 <= first_slot ? imem_rdata[INSN_W +: INSN_W] : imem_rdata[0 +: INSN_W];
         push_ins1 <= imem_rdata[INSN_W +: INSN_W];
         push_pc0 <= first_slot ? win.pc1 : win.pc0;
         push_pc1 <= win.pc1;
         push_upd0 <= first_slot ? upd1 : upd0;
         push_upd1 <= upd1;
      end
   end

   // Held window is pushed only when the pipe advances
   assign push_cnt = push_cnt_q & {(P_FW+1){iq_ready}};

endmodule

/* source/branch_predictor.sv */
//##########################################################################
// Branch predictor
// Direct-mapped target buffer with 2-bit counters, trained at writeback
//##########################################################################
`timescale 1ns/100ps

module branch_predictor
(
   input                                  clk,
   input                                  rst_n,
   input                                  re,
   input                                  flush,
   input  fetch_pkg::pc_t                 lookup_pc0,
   input  fetch_pkg::pc_t                 lookup_pc1,
   input  [fetch_pkg::FW-1:0]             aligned_s1,
   output logic                           pred_taken,
   output fetch_pkg::pc_t                 pred_tgt,
   output fetch_pkg::bpu_upd_t            upd0,
   output fetch_pkg::bpu_upd_t            upd1,
   input                                  bpu_wb,
   input                                  bpu_wb_taken,
   input  fetch_pkg::pc_t                 bpu_wb_pc,
   input  fetch_pkg::pc_t                 bpu_wb_npc_act,
   input  fetch_pkg::bpu_upd_t            bpu_wb_upd
);
   import fetch_pkg::*;

   logic [BTB_TAG_W-1:0] tag_mem [1<<BTB_P_NUM];
   pc_t tgt_mem [1<<BTB_P_NUM];
   bpu_cnt_t cnt_mem [1<<BTB_P_NUM];
   logic [(1<<BTB_P_NUM)-1:0] vld_mem;

   pc_t lookup_pc [FW];
   logic [BTB_P_NUM-1:0] lk_idx [FW];
   logic [FW-1:0] hit_nxt;
   logic [FW-1:0] hit_q;
   bpu_cnt_t cnt_q [FW];
   pc_t tgt_q [FW];
   logic [FW-1:0] taken;

   logic [BTB_P_NUM-1:0] wb_idx;
   bpu_cnt_t wb_cnt;
   bpu_cnt_t cnt_nxt;

   assign lookup_pc[0] = lookup_pc0;
   assign lookup_pc[1] = lookup_pc1;

   always_comb
   begin
      for (int i = 0; i < FW; i++)
      begin
         lk_idx[i] = lookup_pc[i][BTB_P_NUM-1:0];
         hit_nxt[i] = vld_mem[lk_idx[i]] &&
                      (tag_mem[lk_idx[i]] == lookup_pc[i][PC_W-1:BTB_P_NUM]);
      end
   end

   // Lookup registered together with stage 1
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         hit_q <= '0;
      else if (re | flush)
         hit_q <= hit_nxt & {FW{~flush}};
   end

   always_ff @(posedge clk)
   begin
      if (re)
      begin
         for (int i = 0; i < FW; i++)
         begin
            tgt_q[i] <= tgt_mem[lk_idx[i]];
            // A miss reports the initial counter so training starts clean
            cnt_q[i] <= hit_nxt[i] ? cnt_mem[lk_idx[i]] : BPU_CNT_INIT;
         end
      end
   end

   always_comb
   begin
      for (int i = 0; i < FW; i++)
         taken[i] = hit_q[i] & aligned_s1[i] & cnt_q[i][BPU_TAKEN-1];
   end

   // Lowest taken slot wins
   assign pred_taken = |taken;
   assign pred_tgt = taken[0] ? tgt_q[0] : tgt_q[1];
   assign upd0 = {taken[0], cnt_q[0]};
   assign upd1 = {taken[1], cnt_q[1]};

   assign wb_idx = bpu_wb_pc[BTB_P_NUM-1:0];
   assign wb_cnt = bpu_wb_upd[BPU_TAKEN-1:0];

   // Saturating counter update
   always_comb
   begin
      if (bpu_wb_taken)
         cnt_nxt = (&wb_cnt) ? wb_cnt : wb_cnt + 1'b1;
      else
         cnt_nxt = (~|wb_cnt) ? wb_cnt : wb_cnt - 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         vld_mem <= '0;
         for (int i = 0; i < (1<<BTB_P_NUM); i++)
            cnt_mem[i] <= BPU_CNT_INIT;
      end
      else if (bpu_wb)
      begin
         vld_mem[wb_idx] <= 1'b1;
         cnt_mem[wb_idx] <= cnt_nxt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bpu_wb)
      begin
         tag_mem[wb_idx] <= bpu_wb_pc[PC_W-1:BTB_P_NUM];
         tgt_mem[wb_idx] <= bpu_wb_npc_act;
      end
   end

endmodule

/* source/pc_gen.sv */
//##########################################################################
// PC generator
// Next-PC select, PC register, window alignment and stage-1 registers
//##########################################################################
`timescale 1ns/100ps

module pc_gen
(
   input                                  clk,
   input                                  rst_n,
   input                                  flush,
   input  fetch_pkg::pc_t                 flush_tgt,
   input                                  iq_ready,
   input                                  pred_taken,
   input  fetch_pkg::pc_t                 pred_tgt,
   input  fetch_pkg::cnt_t                push_cnt,
   output logic                           imem_en,
   output logic [fetch_pkg::ADDR_W-1:0]   imem_addr,
   output fetch_pkg::pc_t                 lookup_pc0,
   output fetch_pkg::pc_t                 lookup_pc1,
   fetch_window_if.src                    win
);
   import fetch_pkg::*;

   logic p_ce;
   pc_t pc;
   pc_t pc_nxt;
   pc_t base;
   logic [P_FW-1:0] offset;
   logic [FW-1:0] aligned_nxt;

   assign p_ce = iq_ready;

   always_comb
   begin
      if (flush)
         pc_nxt = flush_tgt;
      else if (!p_ce)
         pc_nxt = pc;
      else if (pred_taken)
         pc_nxt = pred_tgt;
      else
         pc_nxt = pc + pc_t'(push_cnt);
   end

   // Word offset of the entry point inside the window
   assign offset = pc_nxt[P_FW-1:0];
   assign base = pc_nxt - pc_t'(offset);

   always_comb
   begin
      for (int i = 0; i < FW; i++)
         aligned_nxt[i] = (int'(offset) <= i);
   end

   assign lookup_pc0 = base;
   assign lookup_pc1 = base + pc_t'(1);

   assign imem_en = p_ce;
   assign imem_addr = {base, {P_INSN_LEN{1'b0}}};

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         pc <= ERST_VECTOR[ADDR_W-1:P_INSN_LEN];
      else
         pc <= pc_nxt;
   end

   // Stage-1 control, the old window dies on flush
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         win.aligned <= '0;
         win.valid <= 1'b0;
      end
      else if (p_ce | flush)
      begin
         win.aligned <= flush ? '0 : aligned_nxt;
         win.valid <= ~flush;
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         win.pc0 <= lookup_pc0;
         win.pc1 <= lookup_pc1;
      end
   end

endmodule

/* source/fetch_window_if.sv */
//##########################################################################
// Fetch window interface
// One fetch window passed from the PC stage to the align stage
//##########################################################################
`timescale 1ns/100ps

interface fetch_window_if;
   import fetch_pkg::*;

   // Slot PCs after re-alignment to the window base
   pc_t pc0;
   pc_t pc1;
   // Slots at or after the entry word
   logic [FW-1:0] aligned;
   logic valid;

   modport src
   (
      output pc0,
      output pc1,
      output aligned,
      output valid
   );

   modport dst
   (
      input pc0,
      input pc1,
      input aligned,
      input valid
   );

endinterface

/* source/fetch_pkg.sv */
//##########################################################################
// Fetch frontend package
// Widths, types and constants shared by the two-wide fetch stages
//##########################################################################
package fetch_pkg;

   localparam int ADDR_W = 32;
   localparam int P_INSN_LEN = 2;
   localparam int PC_W = ADDR_W - P_INSN_LEN;
   localparam int INSN_W = 32;

   // Fetch window of two instructions
   localparam int FW = 2;
   localparam int P_FW = 1;

   // Target buffer geometry
   localparam int BTB_P_NUM = 4;
   localparam int BTB_TAG_W = PC_W - BTB_P_NUM;

   // Predictor record is {taken, counter}
   localparam int BPU_UPD_W = 3;
   localparam int BPU_TAKEN = BPU_UPD_W - 1;

   // Queue of eight entries, ready while six are free
   localparam int IQ_P_DEPTH = 3;
   localparam int IQ_READY_FREE = 6;

   localparam logic [ADDR_W-1:0] ERST_VECTOR = 32'h0000_0100;

   typedef logic [PC_W-1:0] pc_t;
   typedef logic [P_FW:0] cnt_t;
   typedef logic [INSN_W-1:0] insn_t;
   typedef logic [INSN_W*FW-1:0] window_t;
   typedef logic [BPU_UPD_W-1:0] bpu_upd_t;
   typedef logic [BPU_TAKEN-1:0] bpu_cnt_t;

   // Weakly not taken
   localparam bpu_cnt_t BPU_CNT_INIT = 2'd1;

endpackage
